//--- flist.f
+incdir+include
hw/core_defs_pkg.sv
hw/cache_set_if.sv
hw/icache_controller.sv
hw/cache_set.sv
hw/icache.sv
hw/main_memory.sv
hw/icache_system.sv
testbench/icache_tb.sv

//--- mem_init.hex
// One 32-bit instruction word per line, in hex
// Line n holds the word at word address n (byte address 4*n)
00000513
00100593
00b50633
40c586b3
00d62023
00462703
fe070ee3
00178793
0ff7f813
01079893
4108d913
00291993
01350a33
000a2a83
015a8b33
fffb0b93
0bb12c23
01812c03
018c0cb3
00cc9d13
41ad0db3
01bd8e33
00ce2e83
01de8f33
002f1f93
01ff8033
12345137
67810113
00010197
ff018193
0001a203
0041a283
00520333
0062a023
fc0318e3
00008067
ff010113
00112623
00812423
01010413
fea42623
fec42783
00f707b3
00078513
00c12083
00812403
01010113
00048067
0c8000ef
00a00893
00000073
30200073
10500073
0000100f
0ff0000f
34102573
34202673
30529073
00151513
4015d593
02b50633
02c5c6b3
02d6e733
fe0716e3

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tb
    import core_defs_pkg::*;
();

    localparam int INDEX_W    = $clog2(`ICACHE_LINES);
    localparam int OFFSET_W   = $clog2(`ICACHE_BLOCK_WORDS);
    localparam int TAG_W      = 32 - 2 - INDEX_W - OFFSET_W;
    localparam int N_RANDOM   = 40;                             // Random phase requests
    localparam int N_REQUESTS = 1 + 4 * (1 + `ICACHE_BLOCK_WORDS) + 4 + N_RANDOM;
    localparam int MAX_CYCLES = N_REQUESTS * (`ICACHE_BLOCK_WORDS * (`MEM_LATENCY + 2) + 4)
                                + `ICACHE_LINES + 50;           // Worst case run length

    logic       i_clock;
    logic       i_reset;
    inst_addr_t i_addr;
    logic       i_re;
    inst_t      o_inst;
    logic       o_busy;
    logic       o_hit;

    inst_t            mem_model   [`MEM_WORDS];                 // Copy of the ROM image
    bit               model_valid [`ICACHE_LINES];              // Predicted valid bits
    logic [TAG_W-1:0] model_tag   [`ICACHE_LINES];              // Predicted tags
    integer           seed;
    int               cycle_cnt;

    icache_system icache_system_inst (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_addr  (i_addr),
        .i_re    (i_re),
        .o_inst  (o_inst),
        .o_busy  (o_busy),
        .o_hit   (o_hit));

    always #5 i_clock = ~i_clock;                               // 10 ns period

    // ------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------

    task automatic abort_run(input string line);
        $display("*** TEST FAILED ***");
        $display("%s", line);
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // Run limit
    always @(posedge i_clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            abort_run("Timeout: the cache did not finish the requests in time");
        end
    end

    // Without a request the status outputs stay quiet
    always @(negedge i_clock) begin
        if (!i_reset && !i_re) begin
            assert (o_hit === 1'b0) else mismatch("o_hit", o_hit, 0);
            assert (o_busy === 1'b0) else mismatch("o_busy", o_busy, 0);
        end
    end

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------

    // Invalidate sweep right after reset
    task automatic check_clear_sweep();
        i_re   <= 1'b1;
        i_addr <= '0;
        repeat (`ICACHE_LINES) begin
            @(negedge i_clock);
            assert (o_busy === 1'b1) else mismatch("o_busy", o_busy, 1);
            assert (o_hit === 1'b0) else mismatch("o_hit", o_hit, 0);
        end
    endtask

    // One request with hit or miss predicted by the model
    task automatic fetch(input inst_addr_t addr);
        int               idx;
        logic [TAG_W-1:0] tag;
        bit               hit_expected;
        inst_t            expected;
        idx          = addr[2+OFFSET_W +: INDEX_W];
        tag          = addr[31 -: TAG_W];
        hit_expected = model_valid[idx] && (model_tag[idx] == tag);
        expected     = mem_model[(addr >> 2) % `MEM_WORDS];
        @(posedge i_clock);
        i_addr <= addr;
        i_re   <= 1'b1;
        @(negedge i_clock);
        if (hit_expected) begin
            assert (o_hit === 1'b1) else mismatch("o_hit", o_hit, 1);    // Zero latency
            assert (o_busy === 1'b0) else mismatch("o_busy", o_busy, 0);
        end
        else begin
            assert (o_hit === 1'b0) else mismatch("o_hit", o_hit, 0);
            while (o_hit !== 1'b1) begin                                 // Refill running
                assert (o_busy === 1'b1) else mismatch("o_busy", o_busy, 1);
                @(negedge i_clock);
            end
        end
        assert (o_inst === expected) else mismatch("o_inst", o_inst, expected);
        model_valid[idx] = 1'b1;                                         // Line now present
        model_tag[idx]   = tag;
    endtask

    // Idle gap on the cached address and then on a missing tag of that line
    task automatic idle_cycles(input int n);
        @(posedge i_clock);
        i_re <= 1'b0;                                                    // Address still cached
        @(negedge i_clock);
        if (n > 1) begin
            @(posedge i_clock);
            i_addr <= i_addr ^ 32'h0000_0100;                            // Other tag on the line
            repeat (n - 1) @(negedge i_clock);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        inst_addr_t base;
        inst_addr_t addr;
        int         gap;
        i_clock   = 1'b0;
        i_reset   = 1'b1;
        i_addr    = '0;
        i_re      = 1'b0;
        cycle_cnt = 0;
        seed      = 32'hd737261d;
        foreach (model_valid[i]) model_valid[i] = 1'b0;
        $readmemh("mem_init.hex", mem_model);
        repeat (10) @(posedge i_clock);
        i_reset <= 1'b0;
        check_clear_sweep();
        fetch(32'h0);                                       // First cold miss
        // Cold block, repeat hit, then the rest of the block
        for (int i = 0; i < 4; i++) begin
            base = inst_addr_t'((3 + 4 * i) << (2 + OFFSET_W));
            fetch(base);
            fetch(base);
            for (int w = 1; w < `ICACHE_BLOCK_WORDS; w++) begin
                fetch(base + inst_addr_t'(4 * w));
            end
        end
        // Same index, different tags
        for (int i = 0; i < 2; i++) begin
            fetch(32'h0000_0040);
            fetch(32'h0000_0144);
        end
        // Random requests over four tags with idle gaps
        for (int i = 0; i < N_RANDOM; i++) begin
            addr = inst_addr_t'($random(seed)) & 32'h0000_03fc;
            fetch(addr);
            gap = $random(seed) & 32'h3;
            if (gap != 0) begin
                idle_cycles(gap);
            end
        end
        idle_cycles(2);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- hw/icache_system.sv
`timescale 1ns/1ps

module icache_system
    import core_defs_pkg::*;
(
    input  logic       i_clock,     // Clock
    input  logic       i_reset,     // Synchronous reset
    input  inst_addr_t i_addr,      // CPU fetch address
    input  logic       i_re,        // CPU read request
    output inst_t      o_inst,      // Fetched instruction
    output logic       o_busy,      // Fetch pending
    output logic       o_hit);      // Instruction available

    inst_addr_t mem_addr;           // Cache to memory address
    logic       mem_re;             // Cache read strobe
    logic       mem_busy;           // Memory working
    inst_t      mem_rdata;          // Memory data

    // ------------------------------------------------------------------
    // Instruction cache
    // ------------------------------------------------------------------

    icache icache_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_addr      (i_addr),
        .i_re        (i_re),
        .o_inst      (o_inst),
        .o_busy      (o_busy),
        .o_hit       (o_hit),
        .o_mem_addr  (mem_addr),
        .o_mem_re    (mem_re),
        .i_mem_busy  (mem_busy),
        .i_mem_rdata (mem_rdata));

    // ------------------------------------------------------------------
    // Main memory
    // ------------------------------------------------------------------

    main_memory main_memory_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_addr      (mem_addr),
        .i_re        (mem_re),
        .o_busy      (mem_busy),
        .o_rdata     (mem_rdata));

endmodule

//--- hw/main_memory.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module main_memory
    import core_defs_pkg::*;
(
    input  logic       i_clock,     // Clock
    input  logic       i_reset,     // Synchronous reset
    input  inst_addr_t i_addr,      // Byte address
    input  logic       i_re,        // Read request
    output logic       o_busy,      // Read in progress
    output inst_t      o_rdata);    // Word of last read

    localparam int unsigned ADDR_W = $clog2(`MEM_WORDS);
    localparam int unsigned CNT_W  = $clog2(`MEM_LATENCY + 1);

    inst_t             rom [`MEM_WORDS];    // Program image
    logic [CNT_W-1:0]  lat_cnt;             // Cycles left in read
    logic [ADDR_W-1:0] word_addr;           // Word address of read
    logic              start;               // Read accepted

    initial begin
        $readmemh("mem_init.hex", rom);
    end

    assign o_busy = (lat_cnt != '0);
    assign start  = i_re && !o_busy;

    // Latency counter
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            lat_cnt <= '0;
        end
        else if (start) begin
            lat_cnt <= CNT_W'(`MEM_LATENCY);
        end
        else if (o_busy) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    // Address capture and data return
    always_ff @(posedge i_clock) begin
        if (start) begin
            word_addr <= i_addr[2 +: ADDR_W];       // Wraps modulo memory size
        end
        if (lat_cnt == CNT_W'(1)) begin
            o_rdata <= rom[word_addr];              // Valid once busy drops
        end
    end

endmodule

//--- hw/icache.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache
    import core_defs_pkg::*;
(
    input  logic       i_clock,     // Clock
    input  logic       i_reset,     // Synchronous reset
    input  inst_addr_t i_addr,      // CPU fetch address
    input  logic       i_re,        // CPU read request
    output inst_t      o_inst,      // Fetched instruction
    output logic       o_busy,      // Cache working on request
    output logic       o_hit,       // Instruction available
    output inst_addr_t o_mem_addr,  // Main memory address
    output logic       o_mem_re,    // Main memory read strobe
    input  logic       i_mem_busy,  // Main memory working
    input  inst_t      i_mem_rdata);// Main memory read data

    localparam int unsigned INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int unsigned OFFSET_W = $clog2(`ICACHE_BLOCK_WORDS);
    localparam int unsigned TAG_W    = $bits(inst_addr_t) - 2 - INDEX_W - OFFSET_W;

    logic [TAG_W-1:0]    tag;       // Address tag
    logic [INDEX_W-1:0]  index;     // Address line select
    logic [OFFSET_W-1:0] offset;    // Address word select
    logic                ctrl_busy; // Controller busy, ungated
    logic                ctrl_hit;  // Controller hit, ungated

    cache_set_if set_bus ();

    // Word address split above the byte bits
    assign tag    = i_addr[2+OFFSET_W+INDEX_W +: TAG_W];
    assign index  = i_addr[2+OFFSET_W +: INDEX_W];
    assign offset = i_addr[2 +: OFFSET_W];

    // Memory read address follows the controller
    assign o_mem_addr    = {set_bus.tag, set_bus.index, set_bus.offset, 2'b00};
    assign set_bus.wdata = i_mem_rdata;                     // Refill data path

    // Status only meaningful with a request
    assign o_busy = ctrl_busy & i_re;
    assign o_hit  = ctrl_hit & i_re;

    // ------------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------------

    icache_controller #(
        .INDEX_W    (INDEX_W),
        .OFFSET_W   (OFFSET_W),
        .TAG_W      (TAG_W))
    ctrl_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_re       (i_re),
        .i_tag      (tag),
        .i_index    (index),
        .i_offset   (offset),
        .i_mem_busy (i_mem_busy),
        .o_mem_re   (o_mem_re),
        .o_busy     (ctrl_busy),
        .o_hit      (ctrl_hit),
        .set_bus    (set_bus.ctrl));

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    cache_set set_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .set_bus    (set_bus.set),
        .o_rdata    (o_inst));

endmodule

//--- hw/cache_set.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module cache_set
    import core_defs_pkg::*;
(
    input  logic      i_clock,      // Clock
    input  logic      i_reset,      // Synchronous reset
    cache_set_if.set  set_bus,      // Controller access
    output inst_t     o_rdata);     // Word at index and offset

    localparam int unsigned INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int unsigned OFFSET_W = $clog2(`ICACHE_BLOCK_WORDS);
    localparam int unsigned TAG_W    = $bits(inst_addr_t) - 2 - INDEX_W - OFFSET_W;

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    logic [`ICACHE_LINES-1:0] valid;                                // Line holds a block
    logic [TAG_W-1:0]         tags [`ICACHE_LINES];                 // Tag per line
    inst_t                    data [`ICACHE_LINES][`ICACHE_BLOCK_WORDS]; // Block words

    // Valid bits
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid <= '0;
        end
        else if (set_bus.clear) begin
            valid[set_bus.index] <= 1'b0;                   // Invalidate line
        end
        else if (set_bus.write) begin
            valid[set_bus.index] <= 1'b1;                   // Line now owned by tag
        end
    end

    // Tag and data words
    always_ff @(posedge i_clock) begin
        if (set_bus.write) begin
            tags[set_bus.index]                 <= set_bus.tag;
            data[set_bus.index][set_bus.offset] <= set_bus.wdata;
        end
    end

    // ------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------

    // Combinational hit for the presented address
    assign set_bus.hit = valid[set_bus.index] && (tags[set_bus.index] == set_bus.tag);

    assign o_rdata = data[set_bus.index][set_bus.offset];   // Combinational word read

endmodule

//--- hw/icache_controller.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_controller
    import core_defs_pkg::*;
#(
    parameter int unsigned INDEX_W  = $clog2(`ICACHE_LINES),       // Line select bits
    parameter int unsigned OFFSET_W = $clog2(`ICACHE_BLOCK_WORDS), // Word select bits
    parameter int unsigned TAG_W    = 32 - 2 - INDEX_W - OFFSET_W) // Remaining upper bits
(
    input  logic                i_clock,    // Clock
    input  logic                i_reset,    // Synchronous reset
    input  logic                i_re,       // CPU read request
    input  logic [TAG_W-1:0]    i_tag,      // CPU address tag
    input  logic [INDEX_W-1:0]  i_index,    // CPU address index
    input  logic [OFFSET_W-1:0] i_offset,   // CPU address word offset
    input  logic                i_mem_busy, // Memory still working
    output logic                o_mem_re,   // Memory read strobe
    output logic                o_busy,     // Cache cannot answer yet
    output logic                o_hit,      // Instruction available
    cache_set_if.ctrl           set_bus);   // Storage access

    localparam int unsigned LAST_LINE = `ICACHE_LINES - 1;
    localparam int unsigned LAST_WORD = `ICACHE_BLOCK_WORDS - 1;

    ctrl_state_t         state;         // Current FSM state
    logic [INDEX_W-1:0]  clr_cnt;       // Line being invalidated
    logic [OFFSET_W-1:0] word_cnt;      // Refill word position
    logic [TAG_W-1:0]    miss_tag;      // Tag of missing block
    logic [INDEX_W-1:0]  miss_index;    // Line of missing block
    logic                miss;          // Lookup failed on a request
    logic                word_done;     // Memory word ready this cycle

    assign miss      = (state == ST_LOOKUP) && i_re && !set_bus.hit;
    assign word_done = (state == ST_REFILL_WAIT) && !i_mem_busy;

    // ------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state    <= ST_CLEAR;
            clr_cnt  <= '0;
            word_cnt <= '0;
        end
        else begin
            case (state)
                ST_CLEAR: begin
                    clr_cnt <= clr_cnt + 1'b1;              // Next line
                    if (clr_cnt == INDEX_W'(LAST_LINE)) begin
                        state <= ST_LOOKUP;                 // All lines invalid
                    end
                end
                ST_LOOKUP: begin
                    if (miss) begin
                        word_cnt <= '0;                     // Refill from word 0
                        state    <= ST_REFILL_REQ;
                    end
                end
                ST_REFILL_REQ: begin
                    state <= ST_REFILL_WAIT;                // Read accepted by memory
                end
                ST_REFILL_WAIT: begin
                    if (word_done) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == OFFSET_W'(LAST_WORD)) begin
                            state <= ST_LOOKUP;             // Block complete
                        end
                        else begin
                            state <= ST_REFILL_REQ;         // Next word
                        end
                    end
                end
                default: begin
                    state <= ST_CLEAR;
                end
            endcase
        end
    end

    // Miss address held through the refill
    always_ff @(posedge i_clock) begin
        if (miss) begin
            miss_tag   <= i_tag;
            miss_index <= i_index;
        end
    end

    // ------------------------------------------------------------------
    // Storage and memory control
    // ------------------------------------------------------------------

    always_comb begin
        set_bus.tag    = i_tag;                             // Lookup uses CPU address
        set_bus.index  = i_index;
        set_bus.offset = i_offset;
        case (state)
            ST_CLEAR: begin
                set_bus.index = clr_cnt;                    // Sweep the lines
            end
            ST_REFILL_REQ, ST_REFILL_WAIT: begin
                set_bus.tag    = miss_tag;                  // Refill address
                set_bus.index  = miss_index;
                set_bus.offset = word_cnt;
            end
            default: begin
            end
        endcase
    end

    assign set_bus.clear = (state == ST_CLEAR);
    assign set_bus.write = word_done;                       // Word lands on this edge
    assign o_mem_re      = (state == ST_REFILL_REQ);
    assign o_hit         = (state == ST_LOOKUP) && set_bus.hit;
    assign o_busy        = !o_hit;                          // Busy unless hit in lookup

endmodule

//--- hw/cache_set_if.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

interface cache_set_if
    import core_defs_pkg::*;
();

    localparam int unsigned INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int unsigned OFFSET_W = $clog2(`ICACHE_BLOCK_WORDS);
    localparam int unsigned TAG_W    = $bits(inst_addr_t) - 2 - INDEX_W - OFFSET_W;

    logic                write;     // Store wdata, mark line valid
    logic                clear;     // Invalidate indexed line
    logic [TAG_W-1:0]    tag;       // Tag to compare or store
    logic [INDEX_W-1:0]  index;     // Line select
    logic [OFFSET_W-1:0] offset;    // Word within the line
    inst_t               wdata;     // Refill word from memory
    logic                hit;       // Valid line with matching tag

    // Controller side
    modport ctrl (
        output write,
        output clear,
        output tag,
        output index,
        output offset,
        input  hit
    );

    // Storage side
    modport set (
        input  write,
        input  clear,
        input  tag,
        input  index,
        input  offset,
        input  wdata,
        output hit
    );

endinterface

//--- hw/core_defs_pkg.sv
package core_defs_pkg;

    // ------------------------------------------------------------------
    // Fetch path types
    // ------------------------------------------------------------------

    typedef logic [31:0] inst_addr_t;   // Byte address, word aligned
    typedef logic [31:0] inst_t;        // Instruction word

    // ------------------------------------------------------------------
    // Cache controller states
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        ST_CLEAR,                       // Invalidate one line per cycle
        ST_LOOKUP,                      // Normal hit check
        ST_REFILL_REQ,                  // Issue one memory read
        ST_REFILL_WAIT                  // Wait for memory, then write word
    } ctrl_state_t;

endpackage

//--- include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ----------------------------------------------------------------------
// Cache geometry
// ----------------------------------------------------------------------

`define ICACHE_LINES       16   // Lines in the direct-mapped cache
`define ICACHE_BLOCK_WORDS 4    // Instruction words per line

// ----------------------------------------------------------------------
// Main memory model
// ----------------------------------------------------------------------

`define MEM_WORDS          64   // ROM size in words
`define MEM_LATENCY        3    // Busy cycles per read

`endif
